// ==== sensor_pkg.sv ====
// sensor supervisor shared definitions
package sensor_pkg;

	// ====================
	// common types
	// ====================
	typedef logic [7:0] reg_byte_t; // register address or data byte
	typedef logic [11:0] touch_status_t; // ele11 .. ele0
	typedef logic [2:0] ads_ctrl_code_t; // ads1292 control bits

	// one rdatac sample, status word then both channels
	typedef struct packed {
		logic [23:0] status;
		logic [23:0] ch1;
		logic [23:0] ch2;
	} ads_sample_t;

	typedef struct packed {
		reg_byte_t header; // report kind
		logic [71:0] body; // payload, msb first
	} uart_frame_t;

	typedef struct packed {
		reg_byte_t cmd; // command code
		reg_byte_t arg; // register address for reads
	} uart_rx_word_t;

	// ====================
	// uart codes
	// ====================
	localparam reg_byte_t HDR_ADS_DATA = 8'hAA;
	localparam reg_byte_t HDR_MPR_DATA = 8'hBB;
	localparam reg_byte_t HDR_ADS_REG = 8'h61; // 'a', also the ads read command
	localparam reg_byte_t HDR_MPR_REG = 8'h6D; // 'm', also the mpr read command
	localparam reg_byte_t CMD_RUN = 8'h52; // 'R'
	localparam reg_byte_t CMD_STOP = 8'h53; // 'S'

	// ads1292 control port codes
	localparam ads_ctrl_code_t ADS_CB_RREG = 3'b011;
	localparam ads_ctrl_code_t ADS_CB_RDATAC = 3'b100;
	localparam ads_ctrl_code_t ADS_CB_SDATAC = 3'b101;
	localparam ads_ctrl_code_t ADS_CB_DUMMY = 3'b111; // no operation

	// ====================
	// mpr121 registers
	// ====================
	localparam reg_byte_t MPR_TOUCH0_REG = 8'h00; // ele0..ele7
	localparam reg_byte_t MPR_TOUCH1_REG = 8'h01; // ele8..ele11 in low nibble
	localparam reg_byte_t MPR_ELE_CONFIG_REG = 8'h5E;
	localparam reg_byte_t MPR_ELE_RUN = 8'h8F; // all 12 electrodes on
	localparam reg_byte_t MPR_ELE_STOP = 8'h00;

	// start-up writes, each entry is {addr, data}
	localparam int MPR_INIT_COUNT = 14;
	localparam int MPR_INIT_IDX_W = $clog2(MPR_INIT_COUNT);
	localparam logic [0:MPR_INIT_COUNT-1][15:0] MPR_INIT_TABLE = {
		16'h2B01, // mhdr
		16'h2C01, // nhdar
		16'h2D0E, // nclr
		16'h2E00, // fdlr
		16'h2F01, // mhdf
		16'h3005, // nhdaf
		16'h3101, // nclf
		16'h3200, // fdlf
		16'h3300, // nhdat
		16'h3400, // nclt
		16'h3500, // fdlt
		16'h5B00, // debounce
		16'h5C10, // filter cdc
		16'h5D20  // filter cdt
	};

endpackage

// ==== mpr_cmd_if.sv ====
// mpr121 access request bus
`timescale 1ns/100ps

interface mpr_cmd_if;
	logic start; // one-cycle request, only while idle
	logic write; // 1 write, 0 read
	sensor_pkg::reg_byte_t addr;
	sensor_pkg::reg_byte_t wdata;
	logic done; // one pulse per start
	logic fail; // valid with done
	sensor_pkg::reg_byte_t rdata; // valid with done

	// sequencer side
	modport ctrl (
		output start, write, addr, wdata,
		input done, fail, rdata
	);

	// register access engine side
	modport engine (
		input start, write, addr, wdata,
		output done, fail, rdata
	);
endinterface

// ==== uart_cmd_decoder.sv ====
// uart command decoder
`timescale 1ns/100ps

module uart_cmd_decoder (
	input logic i_CLK,
	input logic i_RST,
	input sensor_pkg::uart_rx_word_t i_rx_word,
	input logic i_rx_valid,
	input logic i_mpr_reg_taken, // mpr register report left
	input logic i_ads_reg_taken, // ads register report left
	output logic o_run_mode,
	output logic o_mpr_read_mode,
	output logic o_ads_read_mode,
	output sensor_pkg::reg_byte_t o_read_addr
);

	sensor_pkg::uart_rx_word_t r_word; // latched rx word
	logic r_word_vld; // decode strobe, one cycle after rx valid
	logic c_is_read;

	assign c_is_read = (r_word.cmd == sensor_pkg::HDR_MPR_REG) ||
		(r_word.cmd == sensor_pkg::HDR_ADS_REG);

	always_ff @(posedge i_CLK, posedge i_RST) begin
		if (i_RST) begin
			r_word_vld <= 1'b0;
			o_run_mode <= 1'b0;
			o_mpr_read_mode <= 1'b0;
			o_ads_read_mode <= 1'b0;
		end else begin
			r_word_vld <= i_rx_valid;
			if (i_mpr_reg_taken) o_mpr_read_mode <= 1'b0;
			if (i_ads_reg_taken) o_ads_read_mode <= 1'b0;
			// a new command wins over a clear in the same cycle
			if (r_word_vld) begin
				case (r_word.cmd)
					sensor_pkg::CMD_RUN: o_run_mode <= 1'b1;
					sensor_pkg::CMD_STOP: o_run_mode <= 1'b0;
					sensor_pkg::HDR_MPR_REG: o_mpr_read_mode <= 1'b1;
					sensor_pkg::HDR_ADS_REG: o_ads_read_mode <= 1'b1;
					default: ; // unknown codes dropped
				endcase
			end
		end
	end

	// payload
	always_ff @(posedge i_CLK) begin
		if (i_rx_valid) r_word <= i_rx_word;
		if (r_word_vld && c_is_read) o_read_addr <= r_word.arg;
	end

endmodule

// ==== sensor_supervisor.sv ====
// sensor supervisor state machine
`timescale 1ns/100ps

module sensor_supervisor (
	input logic i_CLK,
	input logic i_RST,
	input logic i_mpr_init_set, // chip powered up
	input logic i_run_mode,
	input logic i_mpr_read_mode,
	input logic i_mpr_setup_done, // start-up table written
	input logic i_mpr_running, // electrodes on, polling
	output logic o_mpr_setup_req,
	output logic o_mpr_run_req,
	output logic o_mpr_read_req,
	output logic o_chip_set,
	output logic o_run_set,
	output logic o_core_busy
);

	typedef enum logic [1:0] {ST_WAIT_INIT, ST_CHIP_SET, ST_STANDBY, ST_READING} state_t;
	state_t r_state;
	logic c_active; // past chip setup

	// ====================
	// requests to mpr121
	// ====================
	assign c_active = (r_state == ST_STANDBY) || (r_state == ST_READING);
	assign o_mpr_setup_req = (r_state == ST_CHIP_SET);
	assign o_mpr_run_req = c_active && i_run_mode; // low level means stop
	assign o_mpr_read_req = (r_state == ST_STANDBY) && i_mpr_read_mode && !i_run_mode;

	always_ff @(posedge i_CLK, posedge i_RST) begin
		if (i_RST) begin
			r_state <= ST_WAIT_INIT;
			o_chip_set <= 1'b0;
			o_run_set <= 1'b0;
			o_core_busy <= 1'b0;
		end else begin
			// status outputs trail the mpr side by one cycle
			o_chip_set <= i_mpr_setup_done;
			o_run_set <= i_mpr_running;
			o_core_busy <= (r_state == ST_READING) && i_mpr_running;
			case (r_state)
				ST_WAIT_INIT: if (i_mpr_init_set) r_state <= ST_CHIP_SET;
				ST_CHIP_SET: if (o_chip_set) r_state <= ST_STANDBY;
				ST_STANDBY: if (i_run_mode && o_run_set) r_state <= ST_READING;
				ST_READING: if (!i_run_mode) r_state <= ST_STANDBY;
				default: r_state <= ST_WAIT_INIT;
			endcase
		end
	end

endmodule

// ==== mpr_ctrl.sv ====
// mpr121 sequencer
`timescale 1ns/100ps

module mpr_ctrl (
	input logic i_CLK,
	input logic i_RST,
	input logic i_setup_req,
	input logic i_run_req,
	input logic i_read_req,
	input sensor_pkg::reg_byte_t i_read_addr,
	input logic i_touch_taken,
	input logic i_reg_taken,
	mpr_cmd_if.ctrl bus,
	output logic o_setup_done,
	output logic o_running,
	output sensor_pkg::touch_status_t o_touch_status,
	output logic o_touch_pending,
	output sensor_pkg::uart_frame_t o_touch_frame,
	output logic o_reg_pending,
	output sensor_pkg::uart_frame_t o_reg_frame,
	output logic o_error // sticky until reset
);

	typedef enum logic [1:0] {ST_IDLE, ST_POLL, ST_WAIT} state_t;
	typedef enum logic [2:0] {OP_SETUP, OP_RUN, OP_STOP, OP_POLL, OP_READ} op_t;

	state_t r_state;
	op_t r_op, c_op; // what the open access is for
	logic [sensor_pkg::MPR_INIT_IDX_W-1:0] r_idx; // start-up table entry
	logic r_phase; // 0 touch0, 1 touch1
	logic c_issue, c_write, c_ok;
	sensor_pkg::reg_byte_t c_addr, c_wdata;

	assign c_ok = (r_state == ST_WAIT) && bus.done && !bus.fail; // good completion

	// ====================
	// next access
	// ====================
	always_comb begin
		c_issue = 1'b0;
		c_write = 1'b1;
		c_addr = sensor_pkg::MPR_ELE_CONFIG_REG;
		c_wdata = sensor_pkg::MPR_ELE_STOP; // defaults form the stop write
		c_op = OP_STOP;
		case (r_state)
			ST_IDLE: begin
				if (i_setup_req && !o_setup_done) begin
					c_issue = 1'b1;
					c_addr = sensor_pkg::MPR_INIT_TABLE[r_idx][15:8];
					c_wdata = sensor_pkg::MPR_INIT_TABLE[r_idx][7:0];
					c_op = OP_SETUP;
				end else if (i_run_req && !o_running) begin
					c_issue = 1'b1;
					c_wdata = sensor_pkg::MPR_ELE_RUN;
					c_op = OP_RUN;
				end else if (!i_run_req && o_running) begin
					c_issue = 1'b1; // electrodes off
				end else if (!o_running && i_read_req && !o_reg_pending) begin
					c_issue = 1'b1;
					c_write = 1'b0;
					c_addr = i_read_addr;
					c_op = OP_READ;
				end
			end
			ST_POLL: begin
				if (!i_run_req) begin
					c_issue = 1'b1;
				end else if (!o_touch_pending) begin // wait for last report to leave
					c_issue = 1'b1;
					c_write = 1'b0;
					c_addr = r_phase ? sensor_pkg::MPR_TOUCH1_REG : sensor_pkg::MPR_TOUCH0_REG;
					c_op = OP_POLL;
				end
			end
			default: ;
		endcase
	end

	always_ff @(posedge i_CLK, posedge i_RST) begin
		if (i_RST) begin
			r_state <= ST_IDLE;
			r_op <= OP_SETUP;
			r_idx <= '0;
			r_phase <= 1'b0;
			bus.start <= 1'b0;
			o_setup_done <= 1'b0;
			o_running <= 1'b0;
			o_touch_status <= '0;
			o_touch_pending <= 1'b0;
			o_reg_pending <= 1'b0;
			o_error <= 1'b0;
		end else begin
			bus.start <= c_issue;
			if (i_touch_taken) o_touch_pending <= 1'b0;
			if (i_reg_taken) o_reg_pending <= 1'b0;
			if (c_issue) begin
				r_op <= c_op;
				r_state <= ST_WAIT;
			end else if (r_state == ST_IDLE && o_running && i_run_req) begin
				r_state <= ST_POLL; // resume polling
			end
			if (r_state == ST_WAIT && bus.done) begin
				r_state <= ST_IDLE;
				if (bus.fail) o_error <= 1'b1;
			end
			if (c_ok) begin
				case (r_op)
					OP_SETUP: begin
						if (r_idx == sensor_pkg::MPR_INIT_IDX_W'(sensor_pkg::MPR_INIT_COUNT - 1))
							o_setup_done <= 1'b1;
						else
							r_idx <= r_idx + 1'b1;
					end
					OP_RUN: begin
						o_running <= 1'b1;
						r_state <= ST_POLL;
					end
					OP_STOP: o_running <= 1'b0;
					OP_POLL: begin
						r_phase <= !r_phase;
						r_state <= ST_POLL;
						if (!r_phase) begin
							o_touch_status[7:0] <= bus.rdata;
						end else begin
							o_touch_status[11:8] <= bus.rdata[3:0];
							o_touch_pending <= 1'b1; // both halves in
						end
					end
					default: o_reg_pending <= 1'b1; // register read
				endcase
			end
		end
	end

	// payload
	always_ff @(posedge i_CLK) begin
		if (c_issue) begin
			bus.write <= c_write;
			bus.addr <= c_addr;
			bus.wdata <= c_wdata;
		end
		if (c_ok && r_op == OP_POLL && r_phase)
			o_touch_frame <= {sensor_pkg::HDR_MPR_DATA, 4'b0, bus.rdata[3:0],
				o_touch_status[7:0], 56'b0};
		if (c_ok && r_op == OP_READ)
			o_reg_frame <= {sensor_pkg::HDR_MPR_REG, bus.addr, bus.rdata, 56'b0};
	end

endmodule

// ==== mpr_reg_access.sv ====
// mpr121 register access engine
`timescale 1ns/100ps

module mpr_reg_access (
	input logic i_CLK,
	input logic i_RST,
	input sensor_pkg::reg_byte_t i_data_out, // read data from chip
	input logic i_busy,
	input logic i_fail,
	mpr_cmd_if.engine bus,
	output sensor_pkg::reg_byte_t o_reg_addr,
	output sensor_pkg::reg_byte_t o_data_in,
	output logic o_write_en,
	output logic o_read_en
);

	typedef enum logic [1:0] {ST_IDLE, ST_ADDR, ST_EN, ST_WAIT} state_t;
	state_t r_state;
	logic r_write; // latched direction
	logic c_end; // chip finished

	assign c_end = (r_state == ST_WAIT) && !i_busy;

	always_ff @(posedge i_CLK, posedge i_RST) begin
		if (i_RST) begin
			r_state <= ST_IDLE;
			o_write_en <= 1'b0;
			o_read_en <= 1'b0;
			bus.done <= 1'b0;
			bus.fail <= 1'b0;
		end else begin
			bus.done <= 1'b0;
			case (r_state)
				ST_IDLE: if (bus.start) r_state <= ST_ADDR;
				ST_ADDR: begin // address settles on the port
					o_write_en <= r_write;
					o_read_en <= !r_write;
					r_state <= ST_EN;
				end
				ST_EN: begin // single enable pulse
					o_write_en <= 1'b0;
					o_read_en <= 1'b0;
					r_state <= ST_WAIT;
				end
				default: begin
					if (c_end) begin
						bus.done <= 1'b1;
						bus.fail <= i_fail;
						r_state <= ST_IDLE;
					end
				end
			endcase
		end
	end

	// payload
	always_ff @(posedge i_CLK) begin
		if (r_state == ST_IDLE && bus.start) begin
			o_reg_addr <= bus.addr;
			o_data_in <= bus.wdata;
			r_write <= bus.write;
		end
		if (c_end) bus.rdata <= i_data_out;
	end

endmodule

// ==== ads_ctrl.sv ====
// ads1292 controller
`timescale 1ns/100ps

module ads_ctrl (
	input logic i_CLK,
	input logic i_RST,
	input logic i_run_mode,
	input logic i_read_mode,
	input sensor_pkg::reg_byte_t i_read_addr,
	input sensor_pkg::ads_sample_t i_data_out,
	input logic i_data_ready, // new sample in rdatac mode
	input logic i_busy,
	input logic i_sample_taken,
	input logic i_reg_taken,
	output sensor_pkg::ads_ctrl_code_t o_control,
	output sensor_pkg::reg_byte_t o_reg_addr,
	output logic o_sample_pending,
	output sensor_pkg::uart_frame_t o_sample_frame,
	output logic o_reg_pending,
	output sensor_pkg::uart_frame_t o_reg_frame
);

	typedef enum logic [1:0] {ST_IDLE, ST_STREAM, ST_RREG, ST_RWAIT} state_t;
	state_t r_state;
	sensor_pkg::ads_sample_t r_cap; // captured sample
	logic r_cap_vld;
	logic c_rreg_go, c_rreg_end;

	// register reads only outside run
	assign c_rreg_go = (r_state == ST_IDLE) && !i_run_mode && i_read_mode && !o_reg_pending;
	assign c_rreg_end = (r_state == ST_RWAIT) && !i_busy;

	always_ff @(posedge i_CLK, posedge i_RST) begin
		if (i_RST) begin
			r_state <= ST_IDLE;
			o_control <= sensor_pkg::ADS_CB_DUMMY;
			r_cap_vld <= 1'b0;
			o_sample_pending <= 1'b0;
			o_reg_pending <= 1'b0;
		end else begin
			r_cap_vld <= (r_state == ST_STREAM) && i_run_mode && i_data_ready;
			// newer sample overwrites one still waiting
			if (r_cap_vld) o_sample_pending <= 1'b1;
			else if (i_sample_taken) o_sample_pending <= 1'b0;
			if (i_reg_taken) o_reg_pending <= 1'b0;
			case (r_state)
				ST_IDLE: begin
					o_control <= sensor_pkg::ADS_CB_DUMMY;
					if (i_run_mode) begin
						o_control <= sensor_pkg::ADS_CB_RDATAC; // held while streaming
						r_state <= ST_STREAM;
					end else if (c_rreg_go) begin
						o_control <= sensor_pkg::ADS_CB_RREG;
						r_state <= ST_RREG;
					end
				end
				ST_STREAM: begin
					if (!i_run_mode) begin
						o_control <= sensor_pkg::ADS_CB_SDATAC; // one cycle, then dummy
						r_state <= ST_IDLE;
					end
				end
				ST_RREG: begin
					o_control <= sensor_pkg::ADS_CB_DUMMY;
					r_state <= ST_RWAIT;
				end
				default: begin
					if (c_rreg_end) begin
						o_reg_pending <= 1'b1;
						r_state <= ST_IDLE;
					end
				end
			endcase
		end
	end

	// payload
	always_ff @(posedge i_CLK) begin
		if (i_data_ready) r_cap <= i_data_out;
		if (r_cap_vld) o_sample_frame <= {sensor_pkg::HDR_ADS_DATA, r_cap};
		if (c_rreg_go) o_reg_addr <= i_read_addr;
		if (c_rreg_end)
			o_reg_frame <= {sensor_pkg::HDR_ADS_REG, o_reg_addr, i_data_out[7:0], 56'b0};
	end

endmodule

// ==== tx_report_arbiter.sv ====
// uart transmit report arbiter
`timescale 1ns/100ps

module tx_report_arbiter (
	input logic i_CLK,
	input logic i_RST,
	input logic i_tx_ready,
	input logic i_rx_valid, // rx has the port this cycle
	input logic i_ads_pending,
	input sensor_pkg::uart_frame_t i_ads_frame,
	input logic i_touch_pending,
	input sensor_pkg::uart_frame_t i_touch_frame,
	input logic i_ads_reg_pending,
	input sensor_pkg::uart_frame_t i_ads_reg_frame,
	input logic i_mpr_reg_pending,
	input sensor_pkg::uart_frame_t i_mpr_reg_frame,
	output logic o_ads_taken,
	output logic o_touch_taken,
	output logic o_ads_reg_taken,
	output logic o_mpr_reg_taken,
	output sensor_pkg::uart_frame_t o_tx_frame,
	output logic o_tx_valid
);

	logic [3:0] c_grant; // one-hot, bit 0 highest

	// ====================
	// fixed priority
	// ====================
	always_comb begin
		c_grant = 4'b0000;
		if (i_tx_ready && !i_rx_valid) begin
			if (i_ads_pending) c_grant[0] = 1'b1;
			else if (i_touch_pending) c_grant[1] = 1'b1;
			else if (i_ads_reg_pending) c_grant[2] = 1'b1;
			else if (i_mpr_reg_pending) c_grant[3] = 1'b1;
		end
	end

	assign {o_mpr_reg_taken, o_ads_reg_taken, o_touch_taken, o_ads_taken} = c_grant;

	always_ff @(posedge i_CLK, posedge i_RST) begin
		if (i_RST) o_tx_valid <= 1'b0;
		else o_tx_valid <= |c_grant; // one pulse per grant
	end

	// frame follows the grant by one cycle
	always_ff @(posedge i_CLK) begin
		if (c_grant[0]) o_tx_frame <= i_ads_frame;
		else if (c_grant[1]) o_tx_frame <= i_touch_frame;
		else if (c_grant[2]) o_tx_frame <= i_ads_reg_frame;
		else if (c_grant[3]) o_tx_frame <= i_mpr_reg_frame;
	end

endmodule

// ==== sensor_core_top.sv ====
// sensor core top level
`timescale 1ns/100ps

module sensor_core_top (
	// uart
	output sensor_pkg::uart_frame_t o_UART_DATA_TX,
	output logic o_UART_DATA_TX_VALID,
	input logic i_UART_DATA_TX_READY,
	input sensor_pkg::uart_rx_word_t i_UART_DATA_RX,
	input logic i_UART_DATA_RX_VALID,
	// mpr121
	input sensor_pkg::reg_byte_t i_MPR121_DATA_OUT,
	output sensor_pkg::reg_byte_t o_MPR121_REG_ADDR,
	output sensor_pkg::reg_byte_t o_MPR121_DATA_IN,
	output logic o_MPR121_WRITE_ENABLE,
	output logic o_MPR121_READ_ENABLE,
	input logic i_MPR121_INIT_SET,
	input logic i_MPR121_BUSY,
	input logic i_MPR121_FAIL,
	output sensor_pkg::touch_status_t o_MPR121_TOUCH_STATUS,
	output logic o_MPR121_ERROR,
	// ads1292
	input sensor_pkg::ads_sample_t i_ADS1292_DATA_OUT,
	output sensor_pkg::ads_ctrl_code_t o_ADS1292_CONTROL,
	output sensor_pkg::reg_byte_t o_ADS1292_REG_ADDR,
	input logic i_ADS1292_DATA_READY,
	input logic i_ADS1292_BUSY,
	// system
	output logic o_CHIP_SET,
	output logic o_RUN_SET,
	output logic o_CORE_BUSY,
	input logic i_CLK,
	input logic i_RST
);

	logic run_mode, mpr_read_mode, ads_read_mode;
	sensor_pkg::reg_byte_t read_addr;
	logic mpr_setup_req, mpr_run_req, mpr_read_req, mpr_setup_done, mpr_running;
	logic touch_pending, mpr_reg_pending, ads_pending, ads_reg_pending;
	sensor_pkg::uart_frame_t touch_frame, mpr_reg_frame, ads_frame, ads_reg_frame;
	logic touch_taken, mpr_reg_taken, ads_taken, ads_reg_taken;

	mpr_cmd_if mpr_bus ();

	uart_cmd_decoder u_decoder (
		.i_CLK(i_CLK), .i_RST(i_RST),
		.i_rx_word(i_UART_DATA_RX), .i_rx_valid(i_UART_DATA_RX_VALID),
		.i_mpr_reg_taken(mpr_reg_taken), .i_ads_reg_taken(ads_reg_taken),
		.o_run_mode(run_mode), .o_mpr_read_mode(mpr_read_mode),
		.o_ads_read_mode(ads_read_mode), .o_read_addr(read_addr)
	);

	sensor_supervisor u_supervisor (
		.i_CLK(i_CLK), .i_RST(i_RST),
		.i_mpr_init_set(i_MPR121_INIT_SET), .i_run_mode(run_mode),
		.i_mpr_read_mode(mpr_read_mode), .i_mpr_setup_done(mpr_setup_done),
		.i_mpr_running(mpr_running),
		.o_mpr_setup_req(mpr_setup_req), .o_mpr_run_req(mpr_run_req),
		.o_mpr_read_req(mpr_read_req), .o_chip_set(o_CHIP_SET),
		.o_run_set(o_RUN_SET), .o_core_busy(o_CORE_BUSY)
	);

	mpr_ctrl u_mpr_ctrl (
		.i_CLK(i_CLK), .i_RST(i_RST),
		.i_setup_req(mpr_setup_req), .i_run_req(mpr_run_req), .i_read_req(mpr_read_req),
		.i_read_addr(read_addr), .i_touch_taken(touch_taken), .i_reg_taken(mpr_reg_taken),
		.bus(mpr_bus.ctrl),
		.o_setup_done(mpr_setup_done), .o_running(mpr_running),
		.o_touch_status(o_MPR121_TOUCH_STATUS),
		.o_touch_pending(touch_pending), .o_touch_frame(touch_frame),
		.o_reg_pending(mpr_reg_pending), .o_reg_frame(mpr_reg_frame),
		.o_error(o_MPR121_ERROR)
	);

	mpr_reg_access u_mpr_access (
		.i_CLK(i_CLK), .i_RST(i_RST),
		.i_data_out(i_MPR121_DATA_OUT), .i_busy(i_MPR121_BUSY), .i_fail(i_MPR121_FAIL),
		.bus(mpr_bus.engine),
		.o_reg_addr(o_MPR121_REG_ADDR), .o_data_in(o_MPR121_DATA_IN),
		.o_write_en(o_MPR121_WRITE_ENABLE), .o_read_en(o_MPR121_READ_ENABLE)
	);

	ads_ctrl u_ads_ctrl (
		.i_CLK(i_CLK), .i_RST(i_RST),
		.i_run_mode(run_mode), .i_read_mode(ads_read_mode), .i_read_addr(read_addr),
		.i_data_out(i_ADS1292_DATA_OUT), .i_data_ready(i_ADS1292_DATA_READY),
		.i_busy(i_ADS1292_BUSY), .i_sample_taken(ads_taken), .i_reg_taken(ads_reg_taken),
		.o_control(o_ADS1292_CONTROL), .o_reg_addr(o_ADS1292_REG_ADDR),
		.o_sample_pending(ads_pending), .o_sample_frame(ads_frame),
		.o_reg_pending(ads_reg_pending), .o_reg_frame(ads_reg_frame)
	);

	tx_report_arbiter u_arbiter (
		.i_CLK(i_CLK), .i_RST(i_RST),
		.i_tx_ready(i_UART_DATA_TX_READY), .i_rx_valid(i_UART_DATA_RX_VALID),
		.i_ads_pending(ads_pending), .i_ads_frame(ads_frame),
		.i_touch_pending(touch_pending), .i_touch_frame(touch_frame),
		.i_ads_reg_pending(ads_reg_pending), .i_ads_reg_frame(ads_reg_frame),
		.i_mpr_reg_pending(mpr_reg_pending), .i_mpr_reg_frame(mpr_reg_frame),
		.o_ads_taken(ads_taken), .o_touch_taken(touch_taken),
		.o_ads_reg_taken(ads_reg_taken), .o_mpr_reg_taken(mpr_reg_taken),
		.o_tx_frame(o_UART_DATA_TX), .o_tx_valid(o_UART_DATA_TX_VALID)
	);

endmodule

// ==== tb_sensor_models.sv ====
// sensor chip models
`timescale 1ns/100ps

// mpr121 register file behind the access port
module mpr121_model (
	input logic i_clk,
	input sensor_pkg::reg_byte_t i_reg_addr,
	input sensor_pkg::reg_byte_t i_data_in,
	input logic i_write_en,
	input logic i_read_en,
	input logic i_force_fail, // fail level seen at end of transfer
	input sensor_pkg::reg_byte_t i_touch0, // touch status low byte
	input sensor_pkg::reg_byte_t i_touch1,
	output sensor_pkg::reg_byte_t o_data_out,
	output logic o_busy,
	output logic o_fail
);

	sensor_pkg::reg_byte_t regs [0:255];
	logic [15:0] wlog [0:63]; // {addr, data} per write, in order
	int wcount = 0;
	int busy_cnt = 0;

	assign o_fail = i_force_fail;

	initial begin
		o_busy = 1'b0;
		o_data_out = '0;
		for (int i = 0; i < 256; i++) regs[i] = 8'(i) ^ 8'h3C;
	end

	always @(posedge i_clk) begin
		if (i_write_en) begin
			regs[i_reg_addr] <= i_data_in;
			wlog[wcount] <= {i_reg_addr, i_data_in};
			wcount <= wcount + 1;
			busy_cnt <= 3; // transfer time
			o_busy <= 1'b1;
		end else if (i_read_en) begin
			if (i_reg_addr == sensor_pkg::MPR_TOUCH0_REG) o_data_out <= i_touch0;
			else if (i_reg_addr == sensor_pkg::MPR_TOUCH1_REG) o_data_out <= i_touch1;
			else o_data_out <= regs[i_reg_addr];
			busy_cnt <= 3;
			o_busy <= 1'b1;
		end else if (busy_cnt > 1) begin
			busy_cnt <= busy_cnt - 1;
		end else begin
			busy_cnt <= 0;
			o_busy <= 1'b0;
		end
	end

endmodule

// ads1292 stream and register model
module ads1292_model (
	input logic i_clk,
	input sensor_pkg::ads_ctrl_code_t i_control,
	input sensor_pkg::reg_byte_t i_reg_addr,
	input sensor_pkg::ads_sample_t i_sample, // next sample to stream
	output sensor_pkg::ads_sample_t o_data_out,
	output logic o_data_ready,
	output logic o_busy
);

	sensor_pkg::ads_sample_t slog [0:255]; // every sample sent, in order
	int scount = 0;
	int tick = 0;
	int busy_cnt = 0;
	logic saw_sdatac = 1'b0;

	initial begin
		o_data_out = '0;
		o_data_ready = 1'b0;
		o_busy = 1'b0;
	end

	always @(posedge i_clk) begin
		o_data_ready <= 1'b0;
		if (busy_cnt > 1) busy_cnt <= busy_cnt - 1;
		else begin
			busy_cnt <= 0;
			o_busy <= 1'b0;
		end
		case (i_control)
			sensor_pkg::ADS_CB_RDATAC: begin
				tick <= tick + 1;
				if (tick == 39) begin // one sample each 40 cycles
					tick <= 0;
					o_data_out <= i_sample;
					o_data_ready <= 1'b1;
					slog[scount] <= i_sample;
					scount <= scount + 1;
				end
			end
			sensor_pkg::ADS_CB_SDATAC: begin
				saw_sdatac <= 1'b1;
				tick <= 0;
			end
			sensor_pkg::ADS_CB_RREG: begin
				// register contents: nibble swap of address, xor c3
				o_data_out <= {64'b0, {i_reg_addr[3:0], i_reg_addr[7:4]} ^ 8'hC3};
				o_busy <= 1'b1;
				busy_cnt <= 3;
			end
			default: ;
		endcase
	end

endmodule

// ==== tb_sensor_core.sv ====
// sensor core testbench
`timescale 1ns/100ps

module tb_sensor_core;

	localparam int CYCLE_LIMIT = 20000; // all behaviors fit well inside

	logic i_CLK, i_RST;
	sensor_pkg::uart_frame_t o_UART_DATA_TX;
	logic o_UART_DATA_TX_VALID, i_UART_DATA_TX_READY, i_UART_DATA_RX_VALID;
	sensor_pkg::uart_rx_word_t i_UART_DATA_RX;
	sensor_pkg::reg_byte_t mpr_dout, mpr_addr, mpr_din;
	logic mpr_we, mpr_re, mpr_init, mpr_busy, mpr_fail, mpr_error;
	sensor_pkg::touch_status_t touch_status;
	sensor_pkg::ads_sample_t ads_dout, next_sample;
	sensor_pkg::ads_ctrl_code_t ads_ctrl;
	sensor_pkg::reg_byte_t ads_addr;
	logic ads_ready, ads_busy, chip_set, run_set, core_busy;
	logic force_fail, no_data;
	sensor_pkg::reg_byte_t touch0, touch1, exp_mpr_addr, exp_mpr_data, exp_ads_addr, exp_ads_data;
	logic [31:0] rng;
	int cycles, n_ads, n_touch, n_mpr_reg, n_ads_reg;

	sensor_core_top u_dut (
		.o_UART_DATA_TX(o_UART_DATA_TX), .o_UART_DATA_TX_VALID(o_UART_DATA_TX_VALID),
		.i_UART_DATA_TX_READY(i_UART_DATA_TX_READY), .i_UART_DATA_RX(i_UART_DATA_RX),
		.i_UART_DATA_RX_VALID(i_UART_DATA_RX_VALID),
		.i_MPR121_DATA_OUT(mpr_dout), .o_MPR121_REG_ADDR(mpr_addr),
		.o_MPR121_DATA_IN(mpr_din), .o_MPR121_WRITE_ENABLE(mpr_we),
		.o_MPR121_READ_ENABLE(mpr_re), .i_MPR121_INIT_SET(mpr_init),
		.i_MPR121_BUSY(mpr_busy), .i_MPR121_FAIL(mpr_fail),
		.o_MPR121_TOUCH_STATUS(touch_status), .o_MPR121_ERROR(mpr_error),
		.i_ADS1292_DATA_OUT(ads_dout), .o_ADS1292_CONTROL(ads_ctrl),
		.o_ADS1292_REG_ADDR(ads_addr), .i_ADS1292_DATA_READY(ads_ready),
		.i_ADS1292_BUSY(ads_busy),
		.o_CHIP_SET(chip_set), .o_RUN_SET(run_set), .o_CORE_BUSY(core_busy),
		.i_CLK(i_CLK), .i_RST(i_RST)
	);

	mpr121_model u_mpr_model (
		.i_clk(i_CLK), .i_reg_addr(mpr_addr), .i_data_in(mpr_din),
		.i_write_en(mpr_we), .i_read_en(mpr_re), .i_force_fail(force_fail),
		.i_touch0(touch0), .i_touch1(touch1),
		.o_data_out(mpr_dout), .o_busy(mpr_busy), .o_fail(mpr_fail)
	);

	ads1292_model u_ads_model (
		.i_clk(i_CLK), .i_control(ads_ctrl), .i_reg_addr(ads_addr), .i_sample(next_sample),
		.o_data_out(ads_dout), .o_data_ready(ads_ready), .o_busy(ads_busy)
	);

	// ====================
	// helpers
	// ====================
	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] s;
		s = x;
		s = s ^ (s << 13);
		s = s ^ (s >> 17);
		s = s ^ (s << 5);
		return s;
	endfunction

	// register report frame with header then addr and data bytes
	function automatic sensor_pkg::uart_frame_t expected_frame(input sensor_pkg::reg_byte_t hdr,
			input sensor_pkg::reg_byte_t addr, input sensor_pkg::reg_byte_t data);
		sensor_pkg::uart_frame_t f;
		f.header = hdr;
		f.body = {addr, data, 56'b0};
		return f;
	endfunction

	function automatic sensor_pkg::uart_frame_t expected_sample_frame(
			input sensor_pkg::ads_sample_t s);
		sensor_pkg::uart_frame_t f;
		f.header = sensor_pkg::HDR_ADS_DATA;
		f.body = {s.status, s.ch1, s.ch2}; // status first
		return f;
	endfunction

	task automatic fail_now(input string msg);
		$display("%s", msg);
		$display("SOME TESTS FAILED");
		$fatal(1);
	endtask

	task automatic check_frame(input string name, input sensor_pkg::uart_frame_t got,
			input sensor_pkg::uart_frame_t exp);
		if (got !== exp) fail_now($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic check_touch(input string name, input sensor_pkg::touch_status_t got,
			input sensor_pkg::touch_status_t exp);
		if (got !== exp) fail_now($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic check_byte(input string name, input sensor_pkg::reg_byte_t got,
			input sensor_pkg::reg_byte_t exp);
		if (got !== exp) fail_now($sformatf("ERR %0t %s got %h expected %h", $time, name, got, exp));
	endtask

	task automatic send_word(input sensor_pkg::reg_byte_t cmd, input sensor_pkg::reg_byte_t arg);
		@(posedge i_CLK);
		#1;
		i_UART_DATA_RX = {cmd, arg};
		i_UART_DATA_RX_VALID = 1'b1;
		@(posedge i_CLK);
		#1;
		i_UART_DATA_RX_VALID = 1'b0;
	endtask

	task automatic new_sample();
		rng = xorshift32(rng);
		next_sample.status = rng[23:0];
		rng = xorshift32(rng);
		next_sample.ch1 = rng[23:0];
		rng = xorshift32(rng);
		next_sample.ch2 = rng[23:0];
	endtask

	// ====================
	// clock, watchdog
	// ====================
	initial begin
		i_CLK = 1'b0;
		forever #5 i_CLK = ~i_CLK;
	end

	always @(posedge i_CLK) begin
		cycles <= cycles + 1;
		if (cycles >= CYCLE_LIMIT) fail_now("timeout: the tests did not finish in time");
	end

	// fresh sample once the model has taken the last one
	always @(posedge i_CLK) begin
		if (ads_ready) begin
			#1;
			new_sample();
		end
	end

	// ====================
	// frame compare
	// ====================
	always @(negedge i_CLK) begin
		if (o_UART_DATA_TX_VALID) begin
			if (no_data && (o_UART_DATA_TX.header == sensor_pkg::HDR_ADS_DATA ||
					o_UART_DATA_TX.header == sensor_pkg::HDR_MPR_DATA))
				fail_now("data frame sent after stop");
			case (o_UART_DATA_TX.header)
				sensor_pkg::HDR_ADS_DATA: begin
					if (n_ads >= u_ads_model.scount) fail_now("ADS frame with no model sample");
					check_frame("o_UART_DATA_TX", o_UART_DATA_TX,
						expected_sample_frame(u_ads_model.slog[n_ads]));
					n_ads = n_ads + 1;
				end
				sensor_pkg::HDR_MPR_DATA: begin
					check_frame("o_UART_DATA_TX", o_UART_DATA_TX, expected_frame(
						sensor_pkg::HDR_MPR_DATA, {4'b0, touch1[3:0]}, touch0));
					check_touch("o_MPR121_TOUCH_STATUS", touch_status, {touch1[3:0], touch0});
					n_touch = n_touch + 1;
				end
				sensor_pkg::HDR_MPR_REG: begin
					check_frame("o_UART_DATA_TX", o_UART_DATA_TX, expected_frame(
						sensor_pkg::HDR_MPR_REG, exp_mpr_addr, exp_mpr_data));
					n_mpr_reg = n_mpr_reg + 1;
				end
				sensor_pkg::HDR_ADS_REG: begin
					check_frame("o_UART_DATA_TX", o_UART_DATA_TX, expected_frame(
						sensor_pkg::HDR_ADS_REG, exp_ads_addr, exp_ads_data));
					n_ads_reg = n_ads_reg + 1;
				end
				default: fail_now("frame with an unknown header");
			endcase
		end
	end

	// ====================
	// stimulus
	// ====================
	initial begin
		cycles = 0;
		n_ads = 0;
		n_touch = 0;
		n_mpr_reg = 0;
		n_ads_reg = 0;
		no_data = 1'b0;
		rng = 32'd6;
		i_RST = 1'b1;
		i_UART_DATA_TX_READY = 1'b1; // port always ready
		i_UART_DATA_RX = '0;
		i_UART_DATA_RX_VALID = 1'b0;
		mpr_init = 1'b0;
		force_fail = 1'b0;
		touch0 = '0;
		touch1 = '0;
		exp_mpr_addr = '0;
		exp_mpr_data = '0;
		exp_ads_addr = '0;
		exp_ads_data = '0;
		new_sample();
		repeat (5) @(posedge i_CLK);
		#1;
		i_RST = 1'b0;

		// idle outputs after reset
		@(posedge i_CLK);
		#1;
		if (mpr_we || mpr_re || o_UART_DATA_TX_VALID || chip_set || run_set || core_busy ||
				mpr_error)
			fail_now("a control output is active after reset");
		if (ads_ctrl !== sensor_pkg::ADS_CB_DUMMY) fail_now("ADS control is not dummy after reset");

		// start-up table
		mpr_init = 1'b1;
		while (!chip_set) @(posedge i_CLK);
		if (u_mpr_model.wcount != sensor_pkg::MPR_INIT_COUNT) fail_now("wrong start-up write count");
		for (int i = 0; i < sensor_pkg::MPR_INIT_COUNT; i++) begin
			check_byte("o_MPR121_REG_ADDR", u_mpr_model.wlog[i][15:8],
				sensor_pkg::MPR_INIT_TABLE[i][15:8]);
			check_byte("o_MPR121_DATA_IN", u_mpr_model.wlog[i][7:0],
				sensor_pkg::MPR_INIT_TABLE[i][7:0]);
		end

		// run, polling and streaming
		rng = xorshift32(rng);
		touch0 = rng[7:0];
		touch1 = rng[15:8];
		send_word(sensor_pkg::CMD_RUN, 8'h00);
		while (!run_set) @(posedge i_CLK);
		check_byte("o_MPR121_REG_ADDR", u_mpr_model.wlog[u_mpr_model.wcount-1][15:8],
			sensor_pkg::MPR_ELE_CONFIG_REG);
		check_byte("o_MPR121_DATA_IN", u_mpr_model.wlog[u_mpr_model.wcount-1][7:0],
			sensor_pkg::MPR_ELE_RUN);
		while (!core_busy) @(posedge i_CLK);
		while (n_touch < 3 || n_ads < 6) @(posedge i_CLK);

		// stop
		send_word(sensor_pkg::CMD_STOP, 8'h00);
		while (run_set) @(posedge i_CLK);
		check_byte("o_MPR121_REG_ADDR", u_mpr_model.wlog[u_mpr_model.wcount-1][15:8],
			sensor_pkg::MPR_ELE_CONFIG_REG);
		check_byte("o_MPR121_DATA_IN", u_mpr_model.wlog[u_mpr_model.wcount-1][7:0],
			sensor_pkg::MPR_ELE_STOP);
		if (!u_ads_model.saw_sdatac) fail_now("ADS model never saw SDATAC");
		repeat (20) @(posedge i_CLK);
		no_data = 1'b1; // in-flight reports have left
		repeat (200) @(posedge i_CLK);

		// mpr register read of a start-up entry
		exp_mpr_addr = sensor_pkg::MPR_INIT_TABLE[12][15:8];
		exp_mpr_data = sensor_pkg::MPR_INIT_TABLE[12][7:0];
		send_word(sensor_pkg::HDR_MPR_REG, exp_mpr_addr);
		while (n_mpr_reg < 1) @(posedge i_CLK);
		repeat (50) @(posedge i_CLK);
		if (n_mpr_reg != 1) fail_now("MPR register read sent more than one frame");

		// ads register read
		exp_ads_addr = 8'h05;
		exp_ads_data = 8'h50 ^ 8'hC3;
		send_word(sensor_pkg::HDR_ADS_REG, exp_ads_addr);
		while (n_ads_reg < 1) @(posedge i_CLK);
		repeat (50) @(posedge i_CLK);
		if (n_ads_reg != 1) fail_now("ADS register read sent more than one frame");

		// a failed transfer sets a sticky error and the read is retried
		exp_mpr_addr = sensor_pkg::MPR_INIT_TABLE[13][15:8];
		exp_mpr_data = sensor_pkg::MPR_INIT_TABLE[13][7:0];
		#1;
		force_fail = 1'b1;
		send_word(sensor_pkg::HDR_MPR_REG, exp_mpr_addr);
		while (!mpr_error) @(posedge i_CLK);
		#1;
		force_fail = 1'b0;
		while (n_mpr_reg < 2) @(posedge i_CLK);
		repeat (100) begin
			@(posedge i_CLK);
			if (!mpr_error) fail_now("o_MPR121_ERROR cleared before reset");
		end
		if (n_mpr_reg != 2) fail_now("MPR register read after the failed transfer sent extra frames");

		$display("ALL TESTS PASSED");
		$finish;
	end

endmodule

// ==== vlog.f ====
sensor_pkg.sv
mpr_cmd_if.sv
uart_cmd_decoder.sv
sensor_supervisor.sv
mpr_ctrl.sv
mpr_reg_access.sv
ads_ctrl.sv
tx_report_arbiter.sv
sensor_core_top.sv
tb_sensor_models.sv
tb_sensor_core.sv

// ==== run.sh ====
#!/bin/sh
set -e
cd "$(dirname "$0")"
verilator --binary --timing -f vlog.f --top-module tb_sensor_core -o sim_tb
./obj_dir/sim_tb > sim.log 2>&1 || true
cat sim.log
grep -q "ALL TESTS PASSED" sim.log
echo "simulation passed"
